/* sim.f */
mem_pkg.sv
lane_ram.sv
byte_lane_array.sv
ahb_data_phase_ctrl.sv
raw_bypass.sv
ahb_mem_ctrl.sv
tb_ahb_mem_ctrl.sv

/* Bender.yml */
package:
  name: ahb_mem_ctrl

sources:
  - mem_pkg.sv
  - lane_ram.sv
  - byte_lane_array.sv
  - ahb_data_phase_ctrl.sv
  - raw_bypass.sv
  - ahb_mem_ctrl.sv
  - target: simulation
    files:
      - tb_ahb_mem_ctrl.sv

/* tb_ahb_mem_ctrl.sv */
`timescale 1ns/1ps
// tb_ahb_mem_ctrl
// testbench for the 128-bit AHB-Lite memory controller; runs a table of
// writes, reads and idle cycles against a byte-level reference model,
// including back-to-back reads that are forwarded or stalled
module tb_ahb_mem_ctrl;
    import mem_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;

    typedef enum logic [1:0] {op_write, op_read, op_idle, op_desel} op_kind_e;

    typedef struct packed {
        op_kind_e   kind;
        hsize_e     size;
        mem_addr_t  addr;
        logic       b2b;    // read right behind a write
        logic [1:0] stall;  // expected wait states in the data phase
    } op_t;

    localparam int NUM_OPS = 34;
    localparam op_t OPS [NUM_OPS] = '{
        '{op_write, size_qword, 17'h00100, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_write, size_byte,  17'h00103, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_write, size_hword, 17'h0010e, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_write, size_word,  17'h00108, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_read,  size_qword, 17'h00100, 1'b0, 2'd0},
        '{op_write, size_qword, 17'h00200, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_write, size_dword, 17'h00208, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_read,  size_qword, 17'h00200, 1'b0, 2'd0},
        '{op_write, size_qword, 17'h00300, 1'b0, 2'd0},
        '{op_read,  size_word,  17'h00304, 1'b1, 2'd0}, // forwarded
        '{op_write, size_dword, 17'h00300, 1'b0, 2'd0},
        '{op_read,  size_hword, 17'h00302, 1'b1, 2'd0}, // forwarded
        '{op_write, size_byte,  17'h00305, 1'b0, 2'd0},
        '{op_read,  size_word,  17'h00304, 1'b1, 2'd1}, // partly covered
        '{op_write, size_word,  17'h00308, 1'b0, 2'd0},
        '{op_read,  size_word,  17'h00208, 1'b1, 2'd1}, // other row
        '{op_write, size_hword, 17'h0010a, 1'b0, 2'd0},
        '{op_write, size_word,  17'h0010c, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_read,  size_qword, 17'h00100, 1'b0, 2'd0},
        '{op_read,  size_qword, 17'h00200, 1'b0, 2'd0},
        '{op_read,  size_byte,  17'h0030a, 1'b0, 2'd0},
        '{op_desel, size_qword, 17'h00100, 1'b0, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0},
        '{op_read,  size_qword, 17'h00100, 1'b0, 2'd0},
        '{op_write, size_qword, 17'h00400, 1'b0, 2'd0},
        '{op_read,  size_qword, 17'h00400, 1'b1, 2'd0},
        '{op_idle,  size_byte,  17'h00000, 1'b0, 2'd0}
    };

    localparam op_t IDLE_OP = '{op_idle, size_byte, 17'h00000, 1'b0, 2'd0};

    logic      hclk;
    logic      hrst_b;
    logic      hsel;
    htrans_e   htrans;
    hsize_e    hsize;
    mem_addr_t haddr;
    logic      hwrite;
    bus_data_t hwdata;
    bus_data_t hrdata;
    logic      hready;
    hresp_e    hresp;

    logic [7:0] ref_mem [1 << MEM_ADDR_WIDTH];
    bus_data_t  last_wr_data;

    ahb_mem_ctrl u_ahb_mem_ctrl (
        .hclk   (hclk),
        .hrst_b (hrst_b),
        .hsel   (hsel),
        .htrans (htrans),
        .hsize  (hsize),
        .haddr  (haddr),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp)
    );

    always #(CLK_PERIOD / 2) hclk = ~hclk;

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input bus_data_t actual, input bus_data_t expected,
                              input lane_mask_t mask);
        bus_data_t bit_mask;
        for (int n = 0; n < NUM_LANES; n++) begin
            bit_mask[8*n +: 8] = {8{mask[n]}};
        end
        if ((actual & bit_mask) !== (expected & bit_mask)) begin
            $display("Mismatch at %0t: hrdata expected %h actual %h lanes %h", $time,
                     expected & bit_mask, actual & bit_mask, mask);
            fail_run();
        end
    endtask

    task automatic check_ready(input int actual, input int expected);
        if (actual != expected) begin
            $display("Mismatch at %0t: hready wait states expected %0d actual %0d",
                     $time, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_resp(input hresp_e actual, input hresp_e expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: hresp expected %s actual %s", $time,
                     expected.name(), actual.name());
            fail_run();
        end
    endtask

    function automatic bus_data_t rand_data();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic drive_addr(input op_t op);
        hsel   <= op.kind != op_desel;
        htrans <= (op.kind == op_idle) ? trans_idle : trans_nonseq;
        hsize  <= op.size;
        haddr  <= op.addr;
        hwrite <= op.kind != op_read; // idle and desel look like writes
    endtask

    // completes a data phase by updating the model or checking the read
    task automatic complete_transfer(input op_t op, input bus_data_t wdata);
        lane_mask_t mask;
        bus_data_t  expect_data;
        mask = lane_mask(op.size, op.addr[3:0]);
        expect_data = '0;
        if (op.kind == op_write) begin
            for (int n = 0; n < NUM_LANES; n++) begin
                if (mask[n]) begin
                    ref_mem[{op.addr[MEM_ADDR_WIDTH-1:4], 4'(n)}] = wdata[8*n +: 8];
                end
            end
            last_wr_data = wdata;
        end else if (op.kind == op_read) begin
            if (op.b2b && op.stall == 0) begin
                check_data(hrdata, last_wr_data, '1); // whole forwarded row
            end else begin
                for (int n = 0; n < NUM_LANES; n++) begin
                    expect_data[8*n +: 8] = ref_mem[{op.addr[MEM_ADDR_WIDTH-1:4], 4'(n)}];
                end
                check_data(hrdata, expect_data, mask);
            end
        end
    endtask

    always @(posedge hclk) begin
        if (hrst_b) begin
            check_resp(hresp, resp_okay);
        end
    end

    initial begin
        #((NUM_OPS * 10 + RESET_CYCLES + 2) * CLK_PERIOD);
        $display("Timeout: transfers did not finish in the allowed time");
        fail_run();
    end

    initial begin
        op_t       cur;
        op_t       prev;
        logic      prev_valid;
        bus_data_t wr_data;
        int        stalls;
        void'($urandom(32'h6c8c_a1b8));
        hclk   = 1'b0;
        hrst_b = 1'b0;
        hsel   = 1'b0;
        htrans = trans_idle;
        hsize  = size_byte;
        haddr  = '0;
        hwrite = 1'b0;
        hwdata = '0;
        prev   = IDLE_OP;
        prev_valid   = 1'b0;
        wr_data      = '0;
        last_wr_data = '0;
        repeat (RESET_CYCLES) @(posedge hclk);
        hrst_b <= 1'b1;
        @(posedge hclk);
        for (int i = 0; i <= NUM_OPS; i++) begin
            cur = (i < NUM_OPS) ? OPS[i] : IDLE_OP;
            drive_addr(cur);
            if (prev_valid && (prev.kind == op_write || prev.kind == op_desel)) begin
                wr_data = rand_data();
                hwdata <= wr_data;
            end
            stalls = 0;
            @(posedge hclk);
            while (!hready) begin
                stalls++;
                @(posedge hclk);
            end
            check_ready(stalls, prev_valid ? int'(prev.stall) : 0);
            if (prev_valid) begin
                complete_transfer(prev, wr_data);
            end
            prev       = cur;
            prev_valid = 1'b1;
        end
        $display("Regression passed");
        $finish;
    end

endmodule

/* ahb_mem_ctrl.sv */
`timescale 1ns/1ps
// ahb_mem_ctrl
// AHB-Lite slave memory with a 128-bit data bus built from sixteen
// byte-wide RAM lanes. Reads return the whole row; a read right behind
// a write is forwarded or takes one wait state. Responses are always OKAY
module ahb_mem_ctrl (
    input  logic               hclk,
    input  logic               hrst_b,
    input  logic               hsel,
    input  mem_pkg::htrans_e   htrans,
    input  mem_pkg::hsize_e    hsize,
    input  mem_pkg::mem_addr_t haddr,
    input  logic               hwrite,
    input  mem_pkg::bus_data_t hwdata,
    output mem_pkg::bus_data_t hrdata,
    output logic               hready,
    output mem_pkg::hresp_e    hresp
);
    import mem_pkg::*;

    row_addr_t  ram_row;
    lane_mask_t lane_wen;
    logic       bypass_load;
    bus_data_t  ram_rdata;

    assign hresp = resp_okay; // no error cases

    ahb_data_phase_ctrl u_phase_ctrl (
        .hclk        (hclk),
        .hrst_b      (hrst_b),
        .hsel        (hsel),
        .htrans      (htrans),
        .hsize       (hsize),
        .haddr       (haddr),
        .hwrite      (hwrite),
        .hready      (hready),
        .ram_row     (ram_row),
        .lane_wen    (lane_wen),
        .bypass_load (bypass_load)
    );

    // write data goes straight from the bus in the data phase
    byte_lane_array u_lanes (
        .hclk     (hclk),
        .ram_row  (ram_row),
        .lane_wen (lane_wen),
        .wdata    (hwdata),
        .rdata    (ram_rdata)
    );

    raw_bypass u_bypass (
        .hclk        (hclk),
        .hrst_b      (hrst_b),
        .bypass_load (bypass_load),
        .hwdata      (hwdata),
        .ram_rdata   (ram_rdata),
        .hrdata      (hrdata)
    );

endmodule

/* raw_bypass.sv */
`timescale 1ns/1ps
// raw_bypass
// holds the write data forwarded to a covered back-to-back read and
// selects between it and the RAM row for hrdata
module raw_bypass (
    input  logic               hclk,
    input  logic               hrst_b,
    input  logic               bypass_load,
    input  mem_pkg::bus_data_t hwdata,
    input  mem_pkg::bus_data_t ram_rdata,
    output mem_pkg::bus_data_t hrdata
);
    import mem_pkg::*;

    bus_data_t bypass_data;
    logic      bypass_vld;

    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            bypass_vld <= 1'b0;
        end else begin
            bypass_vld <= bypass_load; // valid for the read's data phase only
        end
    end

    always_ff @(posedge hclk) begin
        if (bypass_load) begin
            bypass_data <= hwdata;
        end
    end

    assign hrdata = bypass_vld ? bypass_data : ram_rdata;

    a_bypass_one_cycle: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        bypass_vld |=> !bypass_vld
    );

endmodule

/* ahb_data_phase_ctrl.sv */
`timescale 1ns/1ps
// ahb_data_phase_ctrl
// AHB-Lite address/data phase tracking for the memory controller.
// Captures each accepted transfer, registers the byte write enables,
// detects a read landing in a write's data phase and either flags a
// bypass or inserts one wait state, and picks the RAM row address
module ahb_data_phase_ctrl (
    input  logic                hclk,
    input  logic                hrst_b,
    input  logic                hsel,
    input  mem_pkg::htrans_e    htrans,
    input  mem_pkg::hsize_e     hsize,
    input  mem_pkg::mem_addr_t  haddr,
    input  logic                hwrite,
    output logic                hready,
    output mem_pkg::row_addr_t  ram_row,
    output mem_pkg::lane_mask_t lane_wen,
    output logic                bypass_load
);
    import mem_pkg::*;

    logic       trans_valid;
    logic       trans_clear;
    logic       hwrite_ff;
    hsize_e     hsize_ff;
    mem_addr_t  haddr_ff;
    lane_mask_t live_mask;
    lane_mask_t wr_mask;
    logic       same_row;
    logic       raw_hazard;
    logic       raw_covered;
    logic       raw_stall;

    assign trans_valid = hsel && hready && (htrans == trans_nonseq || htrans == trans_seq);
    assign trans_clear = hready && !trans_valid; // idle, busy or deselected

    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            hwrite_ff <= 1'b0;
        end else if (trans_valid) begin
            hwrite_ff <= hwrite;
        end else if (trans_clear) begin
            hwrite_ff <= 1'b0;
        end
    end

    always_ff @(posedge hclk) begin
        if (trans_valid) begin
            hsize_ff <= hsize;
            haddr_ff <= haddr;
        end
    end

    assign live_mask = lane_mask(hsize, haddr[3:0]);
    assign wr_mask   = lane_mask(hsize_ff, haddr_ff[3:0]);

    // read in the data phase of a write
    assign raw_hazard  = hwrite_ff && trans_valid && !hwrite;
    assign same_row    = haddr_ff[MEM_ADDR_WIDTH-1:4] == haddr[MEM_ADDR_WIDTH-1:4];
    assign raw_covered = same_row && ((live_mask & ~wr_mask) == '0);

    assign bypass_load = raw_hazard && raw_covered;
    assign raw_stall   = raw_hazard && !raw_covered;

    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            hready <= 1'b0;
        end else begin
            hready <= !raw_stall;
        end
    end

    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            lane_wen <= '0;
        end else if (trans_valid && hwrite) begin
            lane_wen <= live_mask;
        end else begin
            lane_wen <= '0;
        end
    end

    // write row during write data phase, stalled read row during the wait state
    assign ram_row = (hwrite_ff || !hready) ? haddr_ff[MEM_ADDR_WIDTH-1:4]
                                            : haddr[MEM_ADDR_WIDTH-1:4];

    // only one wait state per hazard
    a_single_stall: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        $fell(hready) |=> hready
    );

    // byte enables only in a write data phase
    a_wen_after_write: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        (lane_wen != '0) |-> (hwrite_ff && lane_wen == wr_mask)
    );

endmodule

/* byte_lane_array.sv */
`timescale 1ns/1ps
// byte_lane_array
// sixteen byte lanes sharing one row address; slices the bus write data
// into lanes and reassembles the lane outputs into a full row
module byte_lane_array (
    input  logic                hclk,
    input  mem_pkg::row_addr_t  ram_row,
    input  mem_pkg::lane_mask_t lane_wen,
    input  mem_pkg::bus_data_t  wdata,
    output mem_pkg::bus_data_t  rdata
);
    import mem_pkg::*;

    logic [7:0] lane_din  [NUM_LANES];
    logic [7:0] lane_dout [NUM_LANES];

    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        assign lane_din[n]       = wdata[8*n +: 8];
        assign rdata[8*n +: 8]   = lane_dout[n]; // lane n is byte n of the row

        lane_ram u_lane (
            .hclk (hclk),
            .row  (ram_row),
            .din  (lane_din[n]),
            .wen  (lane_wen[n]),
            .dout (lane_dout[n])
        );
    end

endmodule

/* lane_ram.sv */
`timescale 1ns/1ps
// lane_ram
// one byte-wide lane of the row memory, single port,
// synchronous write and registered read
module lane_ram (
    input  logic               hclk,
    input  mem_pkg::row_addr_t row,
    input  logic [7:0]         din,
    input  logic               wen,
    output logic [7:0]         dout
);
    import mem_pkg::*;

    logic [7:0] mem [LANE_DEPTH];

    always_ff @(posedge hclk) begin
        if (wen) begin
            mem[row] <= din;
        end
        dout <= mem[row]; // old contents on a same-row write
    end

endmodule

/* mem_pkg.sv */
// mem_pkg
// shared sizes, AHB encodings and types for the 128-bit AHB-Lite memory
// controller, plus the byte-lane select rule used by writes and hazard checks
package mem_pkg;

    localparam int MEM_ADDR_WIDTH  = 17;
    localparam int DATA_WIDTH      = 128;
    localparam int NUM_LANES       = DATA_WIDTH / 8;
    localparam int LANE_ADDR_WIDTH = MEM_ADDR_WIDTH - 4; // 16 bytes per row
    localparam int LANE_DEPTH      = 2 ** LANE_ADDR_WIDTH;

    typedef enum logic [2:0] {
        size_byte  = 3'b000,
        size_hword = 3'b001,
        size_word  = 3'b010,
        size_dword = 3'b011,
        size_qword = 3'b100
    } hsize_e;

    typedef enum logic [1:0] {
        trans_idle   = 2'b00,
        trans_busy   = 2'b01,
        trans_nonseq = 2'b10,
        trans_seq    = 2'b11
    } htrans_e;

    typedef enum logic [1:0] {
        resp_okay  = 2'b00,
        resp_error = 2'b01
    } hresp_e;

    typedef logic [MEM_ADDR_WIDTH-1:0]  mem_addr_t;
    typedef logic [LANE_ADDR_WIDTH-1:0] row_addr_t;
    typedef logic [DATA_WIDTH-1:0]      bus_data_t;
    typedef logic [NUM_LANES-1:0]       lane_mask_t;

    // byte lanes touched by an aligned transfer of the given size
    function automatic lane_mask_t lane_mask(input hsize_e size, input logic [3:0] addr_lo);
        lane_mask_t mask;
        case (size)
            size_byte: begin
                mask = 16'h0001 << addr_lo;
            end
            size_hword: begin
                mask = 16'h0003 << {addr_lo[3:1], 1'b0};
            end
            size_word: begin
                mask = 16'h000f << {addr_lo[3:2], 2'b00};
            end
            size_dword: begin
                mask = 16'h00ff << {addr_lo[3], 3'b000};
            end
            size_qword: begin
                mask = '1;
            end
            default: begin
                mask = '0; // reserved sizes touch nothing
            end
        endcase
        return mask;
    endfunction

endpackage
